//--- mix_defs.svh
`ifndef MIX_DEFS_SVH
`define MIX_DEFS_SVH

// Field and bus widths
`define MIX_CHAN_W      4
`define MIX_FRAME_W     5
`define MIX_SADDR_W     9       // Channel and frame together
`define MIX_PADDR_W     8
`define MIX_ACC_W       40
`define MIX_SHIFT_W     3       // Window starts at bit shift * 2
`define MIX_SLOT_W      4
`define MIX_DATA_W      16      // Sample and gain
`define MIX_WORD_W      32      // Instruction and result word
`define MIX_OP_W        7

// Memory depths
`define MIX_PROG_DEPTH  256
`define MIX_SMEM_DEPTH  512

// Opcodes
`define MIX_OP_HALT     7'h00
`define MIX_OP_MAC      7'h40
`define MIX_OP_MACZ     7'h41   // Clear, then MAC
`define MIX_OP_OUT      7'h42

`endif

//--- mix_pkg.sv
`include "mix_defs.svh"

package mix_pkg;

    // MAC and MACZ layout
    typedef struct packed {
        logic [`MIX_OP_W-1:0]    op;
        logic [`MIX_FRAME_W-1:0] offset;
        logic [`MIX_CHAN_W-1:0]  chan;
        logic [`MIX_DATA_W-1:0]  gain;
    } mac_fields_t;

    // Output instruction layout
    typedef struct packed {
        logic [`MIX_OP_W-1:0]    op;
        logic [13:0]             rsvd_hi;
        logic [`MIX_SHIFT_W-1:0] shift;
        logic [`MIX_SLOT_W-1:0]  slot;
        logic [3:0]              rsvd_lo;
    } out_fields_t;

    // One program word, read by op
    typedef union packed {
        mac_fields_t mac_f;
        out_fields_t out_f;
    } instr_u;

    typedef struct packed {
        logic                    we;
        logic [`MIX_SADDR_W-1:0] addr;
        logic [`MIX_DATA_W-1:0]  data;
    } smem_req_t;

    typedef struct packed {
        logic [`MIX_PADDR_W-1:0] addr;
        instr_u                  instr;
    } host_prog_t;

    typedef struct packed {
        logic [`MIX_FRAME_W-1:0] frame;
    } run_cmd_t;

    typedef struct packed {
        logic                    error;
        logic [`MIX_PADDR_W-1:0] halt_addr;
    } run_status_t;

    typedef struct packed {
        logic [`MIX_SLOT_W-1:0]  slot;
        logic [`MIX_WORD_W-1:0]  value;
    } mix_result_t;

endpackage

//--- coef_ram.sv
`timescale 1ns/1ps
`include "mix_defs.svh"

module coef_ram (
    input  logic                    ck,
    input  logic                    we,
    input  logic [`MIX_PADDR_W-1:0] waddr,
    input  mix_pkg::instr_u         wdata,
    input  logic [`MIX_PADDR_W-1:0] raddr,
    output mix_pkg::instr_u         rdata
);

    mix_pkg::instr_u mem [`MIX_PROG_DEPTH];

    // Host load port
    always_ff @(posedge ck) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Fetch port, one cycle latency
    always_ff @(posedge ck) begin
        rdata <= mem[raddr];
    end

endmodule

//--- sample_ram.sv
`timescale 1ns/1ps
`include "mix_defs.svh"

module sample_ram (
    input  logic                    ck,
    input  logic                    en,
    input  logic                    we,
    input  logic [`MIX_SADDR_W-1:0] addr,
    input  logic [`MIX_DATA_W-1:0]  wdata,
    output logic [`MIX_DATA_W-1:0]  rdata
);

    logic [`MIX_DATA_W-1:0] mem [`MIX_SMEM_DEPTH];

    always_ff @(posedge ck) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end
            rdata <= mem[addr];   // Read before write
        end
    end

endmodule

//--- sample_arbiter.sv
`timescale 1ns/1ps
`include "mix_defs.svh"

module sample_arbiter (
    input  logic                    ck,
    input  logic                    rst,
    input  logic                    host_req,
    output logic                    host_ack,
    input  mix_pkg::smem_req_t      host_smem,
    input  logic                    seq_req,
    output logic                    seq_ack,
    input  mix_pkg::smem_req_t      seq_smem,
    output logic [`MIX_DATA_W-1:0]  seq_rdata,
    output logic                    mem_en,
    output logic                    mem_we,
    output logic [`MIX_SADDR_W-1:0] mem_addr,
    output logic [`MIX_DATA_W-1:0]  mem_wdata,
    input  logic [`MIX_DATA_W-1:0]  mem_rdata
);

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_ACCESS,
        ARB_WAIT,
        ARB_ACK
    } arb_state_t;

    arb_state_t             state;
    logic                   own_seq;   // Grant holder, 1 = sequencer
    logic                   own_req;
    logic [`MIX_DATA_W-1:0] rdata_q;
    mix_pkg::smem_req_t     sel;

    assign sel     = own_seq ? seq_smem : host_smem;
    assign own_req = own_seq ? seq_req : host_req;

    assign mem_en    = (state == ARB_ACCESS);
    assign mem_we    = mem_en & sel.we;
    assign mem_addr  = sel.addr;
    assign mem_wdata = sel.data;

    assign host_ack  = (state == ARB_ACK) && !own_seq;
    assign seq_ack   = (state == ARB_ACK) && own_seq;
    assign seq_rdata = rdata_q;

    always_ff @(posedge ck) begin
        if (!rst) begin
            state   <= ARB_IDLE;
            own_seq <= 1'b0;
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (seq_req) begin             // Sequencer wins a tie
                        own_seq <= 1'b1;
                        state   <= ARB_ACCESS;
                    end else if (host_req) begin
                        own_seq <= 1'b0;
                        state   <= ARB_ACCESS;
                    end
                end
                ARB_ACCESS: state <= ARB_WAIT;
                ARB_WAIT:   state <= ARB_ACK;
                ARB_ACK: begin
                    if (!own_req) begin            // Hold grant until req drops
                        state <= ARB_IDLE;
                    end
                end
                default:    state <= ARB_IDLE;
            endcase
        end
    end

    // RAM data lands during the wait state
    always_ff @(posedge ck) begin
        if (state == ARB_WAIT) begin
            rdata_q <= mem_rdata;
        end
    end

endmodule

//--- mac_unit.sv
`timescale 1ns/1ps
`include "mix_defs.svh"

module mac_unit (
    input  logic                          ck,
    input  logic                          rst,
    input  logic                          mac_en,
    input  logic                          clear,
    input  logic signed [`MIX_DATA_W-1:0] gain,
    input  logic signed [`MIX_DATA_W-1:0] sample,
    input  logic [`MIX_SHIFT_W-1:0]       shift,
    output logic [`MIX_WORD_W-1:0]        acc_window
);

    logic signed [`MIX_WORD_W-1:0] prod;
    logic signed [`MIX_ACC_W-1:0]  prod_ext;
    logic signed [`MIX_ACC_W-1:0]  acc;
    logic signed [`MIX_ACC_W-1:0]  acc_shifted;
    logic                          en_q;
    logic                          clear_q;

    // Multiplier stage
    always_ff @(posedge ck) begin
        prod <= gain * sample;
    end

    assign prod_ext = {{(`MIX_ACC_W - `MIX_WORD_W){prod[`MIX_WORD_W-1]}}, prod};

    always_ff @(posedge ck) begin
        if (!rst) begin
            en_q    <= 1'b0;
            clear_q <= 1'b0;
            acc     <= '0;
        end else begin
            en_q    <= mac_en;   // Follows the product by one cycle
            clear_q <= clear;
            if (en_q) begin
                acc <= clear_q ? prod_ext : acc + prod_ext;
            end
        end
    end

    // Window at bit 2 * shift, sign fills the top
    assign acc_shifted = acc >>> {shift, 1'b0};
    assign acc_window  = acc_shifted[`MIX_WORD_W-1:0];

endmodule

//--- mix_sequencer.sv
`timescale 1ns/1ps
`include "mix_defs.svh"

module mix_sequencer (
    input  logic                          ck,
    input  logic                          rst,
    input  logic                          run_req,
    output logic                          run_ack,
    input  mix_pkg::run_cmd_t             run_cmd,
    output mix_pkg::run_status_t          run_status,
    output logic [`MIX_PADDR_W-1:0]       prog_addr,
    input  mix_pkg::instr_u               prog_data,
    output logic                          seq_req,
    input  logic                          seq_ack,
    output mix_pkg::smem_req_t            seq_smem,
    input  logic [`MIX_DATA_W-1:0]        seq_rdata,
    output logic                          mac_en,
    output logic                          clear,
    output logic signed [`MIX_DATA_W-1:0] gain,
    output logic signed [`MIX_DATA_W-1:0] sample,
    output logic [`MIX_SHIFT_W-1:0]       shift,
    input  logic [`MIX_WORD_W-1:0]        acc_window,
    output logic                          res_req,
    input  logic                          res_ack,
    output mix_pkg::mix_result_t          result
);

    typedef enum logic [2:0] {
        SEQ_IDLE,
        SEQ_FETCH,
        SEQ_DECODE,
        SEQ_SREQ,
        SEQ_MAC,
        SEQ_OUT,
        SEQ_DONE
    } seq_state_t;

    seq_state_t              state;
    logic [`MIX_PADDR_W-1:0] pc;
    logic [`MIX_FRAME_W-1:0] frame_base;
    logic [`MIX_FRAME_W-1:0] frame_sum;
    logic [`MIX_SADDR_W-1:0] saddr_q;
    logic [`MIX_DATA_W-1:0]  sample_q;
    mix_pkg::instr_u         ir;
    logic                    mac_cnt;     // Second MAC cycle

    assign prog_addr = pc;
    assign run_ack   = (state == SEQ_DONE);

    // Frame wraps inside the channel
    assign frame_sum = frame_base + prog_data.mac_f.offset;
    assign seq_smem  = '{we: 1'b0, addr: saddr_q, data: '0};

    assign mac_en = (state == SEQ_MAC) && !mac_cnt;
    assign clear  = (ir.mac_f.op == `MIX_OP_MACZ);
    assign gain   = ir.mac_f.gain;
    assign sample = sample_q;
    assign shift  = prog_data.out_f.shift;   // Used while decoding an output

    always_ff @(posedge ck) begin
        if (!rst) begin
            state      <= SEQ_IDLE;
            pc         <= '0;
            seq_req    <= 1'b0;
            res_req    <= 1'b0;
            mac_cnt    <= 1'b0;
            run_status <= '0;
        end else begin
            case (state)
                SEQ_IDLE: begin
                    if (run_req) begin
                        pc    <= '0;
                        state <= SEQ_FETCH;
                    end
                end
                SEQ_FETCH: state <= SEQ_DECODE;
                SEQ_DECODE: begin
                    case (prog_data.mac_f.op)
                        `MIX_OP_MAC, `MIX_OP_MACZ: begin
                            seq_req <= 1'b1;
                            state   <= SEQ_SREQ;
                        end
                        `MIX_OP_OUT: begin
                            res_req <= 1'b1;
                            state   <= SEQ_OUT;
                        end
                        `MIX_OP_HALT: begin
                            run_status <= '{error: 1'b0, halt_addr: pc};
                            state      <= SEQ_DONE;
                        end
                        default: begin                // Illegal opcode
                            run_status <= '{error: 1'b1, halt_addr: pc};
                            state      <= SEQ_DONE;
                        end
                    endcase
                end
                SEQ_SREQ: begin
                    if (seq_req && seq_ack) begin
                        seq_req <= 1'b0;
                    end else if (!seq_req && !seq_ack) begin
                        mac_cnt <= 1'b0;
                        state   <= SEQ_MAC;
                    end
                end
                SEQ_MAC: begin
                    mac_cnt <= 1'b1;
                    if (mac_cnt) begin
                        pc    <= pc + 1'b1;
                        state <= SEQ_FETCH;
                    end
                end
                SEQ_OUT: begin
                    if (res_req && res_ack) begin
                        res_req <= 1'b0;
                    end else if (!res_req && !res_ack) begin   // Sink released
                        pc    <= pc + 1'b1;
                        state <= SEQ_FETCH;
                    end
                end
                SEQ_DONE: begin
                    if (!run_req) begin
                        state <= SEQ_IDLE;
                    end
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

    always_ff @(posedge ck) begin
        if (state == SEQ_IDLE && run_req) begin
            frame_base <= run_cmd.frame;
        end
        if (state == SEQ_DECODE) begin
            ir           <= prog_data;
            saddr_q      <= {prog_data.mac_f.chan, frame_sum};
            result.slot  <= prog_data.out_f.slot;
            result.value <= acc_window;
        end
        if (state == SEQ_SREQ && seq_req && seq_ack) begin
            sample_q <= seq_rdata;
        end
    end

endmodule

//--- mix_engine_top.sv
`timescale 1ns/1ps
`include "mix_defs.svh"

module mix_engine_top (
    input  logic                 ck,
    input  logic                 rst,
    input  logic                 prog_we,
    input  mix_pkg::host_prog_t  prog,
    input  logic                 host_req,
    output logic                 host_ack,
    input  mix_pkg::smem_req_t   host_smem,
    input  logic                 run_req,
    output logic                 run_ack,
    input  mix_pkg::run_cmd_t    run_cmd,
    output mix_pkg::run_status_t run_status,
    output logic                 res_req,
    input  logic                 res_ack,
    output mix_pkg::mix_result_t result
);

    logic [`MIX_PADDR_W-1:0]       prog_addr;
    mix_pkg::instr_u               prog_data;
    logic                          seq_req;
    logic                          seq_ack;
    mix_pkg::smem_req_t            seq_smem;
    logic [`MIX_DATA_W-1:0]        seq_rdata;
    logic                          mem_en;
    logic                          mem_we;
    logic [`MIX_SADDR_W-1:0]       mem_addr;
    logic [`MIX_DATA_W-1:0]        mem_wdata;
    logic [`MIX_DATA_W-1:0]        mem_rdata;
    logic                          mac_en;
    logic                          clear;
    logic signed [`MIX_DATA_W-1:0] gain;
    logic signed [`MIX_DATA_W-1:0] sample;
    logic [`MIX_SHIFT_W-1:0]       shift;
    logic [`MIX_WORD_W-1:0]        acc_window;

    coef_ram u_coef_ram (
        .ck    (ck),
        .we    (prog_we),
        .waddr (prog.addr),
        .wdata (prog.instr),
        .raddr (prog_addr),
        .rdata (prog_data)
    );

    sample_ram u_sample_ram (
        .ck    (ck),
        .en    (mem_en),
        .we    (mem_we),
        .addr  (mem_addr),
        .wdata (mem_wdata),
        .rdata (mem_rdata)
    );

    sample_arbiter u_sample_arbiter (
        .ck        (ck),
        .rst       (rst),
        .host_req  (host_req),
        .host_ack  (host_ack),
        .host_smem (host_smem),
        .seq_req   (seq_req),
        .seq_ack   (seq_ack),
        .seq_smem  (seq_smem),
        .seq_rdata (seq_rdata),
        .mem_en    (mem_en),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata)
    );

    mac_unit u_mac_unit (
        .ck         (ck),
        .rst        (rst),
        .mac_en     (mac_en),
        .clear      (clear),
        .gain       (gain),
        .sample     (sample),
        .shift      (shift),
        .acc_window (acc_window)
    );

    mix_sequencer u_mix_sequencer (
        .ck         (ck),
        .rst        (rst),
        .run_req    (run_req),
        .run_ack    (run_ack),
        .run_cmd    (run_cmd),
        .run_status (run_status),
        .prog_addr  (prog_addr),
        .prog_data  (prog_data),
        .seq_req    (seq_req),
        .seq_ack    (seq_ack),
        .seq_smem   (seq_smem),
        .seq_rdata  (seq_rdata),
        .mac_en     (mac_en),
        .clear      (clear),
        .gain       (gain),
        .sample     (sample),
        .shift      (shift),
        .acc_window (acc_window),
        .res_req    (res_req),
        .res_ack    (res_ack),
        .result     (result)
    );

endmodule

//--- mix_checker.sv
`timescale 1ns/1ps

module mix_checker (
    input logic ck,
    input logic rst,
    input logic host_req,
    input logic host_ack,
    input logic seq_req,
    input logic seq_ack
);

    int fail_cnt = 0;   // Failed assertions so far

    // Ack only follows a request that was already up
    a_host_ack_rise: assert property (@(posedge ck) disable iff (!rst)
        $rose(host_ack) |-> $past(host_req))
        else begin
            $error("host_ack rose with no host_req");
            fail_cnt++;
        end
    a_seq_ack_rise: assert property (@(posedge ck) disable iff (!rst)
        $rose(seq_ack) |-> $past(seq_req))
        else begin
            $error("seq_ack rose with no seq_req");
            fail_cnt++;
        end

    // Req drops only once acked
    a_host_req_fall: assert property (@(posedge ck) disable iff (!rst)
        $fell(host_req) |-> host_ack)
        else begin
            $error("host_req fell before host_ack");
            fail_cnt++;
        end
    a_seq_req_fall: assert property (@(posedge ck) disable iff (!rst)
        $fell(seq_req) |-> seq_ack)
        else begin
            $error("seq_req fell before seq_ack");
            fail_cnt++;
        end

    // Ack holds until its req is gone
    a_host_ack_fall: assert property (@(posedge ck) disable iff (!rst)
        $fell(host_ack) |-> !$past(host_req))
        else begin
            $error("host_ack fell while host_req was still high");
            fail_cnt++;
        end
    a_seq_ack_fall: assert property (@(posedge ck) disable iff (!rst)
        $fell(seq_ack) |-> !$past(seq_req))
        else begin
            $error("seq_ack fell while seq_req was still high");
            fail_cnt++;
        end

endmodule

//--- mix_monitor.sv
`timescale 1ns/1ps
`include "mix_defs.svh"

module mix_monitor (
    input logic                 ck,
    input logic                 rst,
    input logic                 prog_we,
    input mix_pkg::host_prog_t  prog,
    input logic                 host_ack,
    input mix_pkg::smem_req_t   host_smem,
    input logic                 run_req,
    input logic                 run_ack,
    input mix_pkg::run_cmd_t    run_cmd,
    input mix_pkg::run_status_t run_status,
    input logic                 res_req,
    input mix_pkg::mix_result_t result
);

    mix_pkg::instr_u      prog_mem [`MIX_PROG_DEPTH];
    logic [15:0]          smem [`MIX_SMEM_DEPTH];
    mix_pkg::mix_result_t exp_q [$];
    mix_pkg::run_status_t got_status = 'x;
    logic                 host_ack_q, run_req_q, run_ack_q, res_req_q;
    int                   errs = 0;
    int                   n_seen = 0;
    int                   pass_tests = 0;
    int                   fail_tests = 0;

    // Walks the shadow program and queues every output it would send
    task automatic model_run(input logic [4:0] frame);
        mix_pkg::instr_u    ins;
        logic signed [39:0] acc;
        logic signed [39:0] win;
        logic signed [31:0] prod;
        logic [4:0]         fr;
        bit                 stop;
        acc  = '0;
        stop = 0;
        for (int pc = 0; pc < `MIX_PROG_DEPTH && !stop; pc++) begin
            ins = prog_mem[pc];
            case (ins.mac_f.op)
                `MIX_OP_MAC, `MIX_OP_MACZ: begin
                    fr   = frame + ins.mac_f.offset;   // Wraps in the channel
                    prod = $signed(ins.mac_f.gain) * $signed(smem[{ins.mac_f.chan, fr}]);
                    acc  = (ins.mac_f.op == `MIX_OP_MACZ) ? 40'(prod) : acc + 40'(prod);
                end
                `MIX_OP_OUT: begin
                    win = acc >>> (2 * ins.out_f.shift);
                    exp_q.push_back('{slot: ins.out_f.slot, value: win[31:0]});
                end
                default: stop = 1;                     // Halt or illegal
            endcase
        end
    endtask

    task automatic check_result(input mix_pkg::mix_result_t got);
        mix_pkg::mix_result_t exp;
        n_seen++;
        if (exp_q.size() == 0) begin
            $display("Result for slot %0d at %0t came with no output expected", got.slot, $time);
            errs++;
        end else begin
            exp = exp_q.pop_front();
            if (got.slot !== exp.slot) begin
                $display("[FAIL] %0t result.slot got %0d expected %0d", $time, got.slot, exp.slot);
                errs++;
            end
            if (got.value !== exp.value) begin
                $display("[FAIL] %0t result.value got %h expected %h",
                         $time, got.value, exp.value);
                errs++;
            end
        end
    endtask

    always @(posedge ck) begin
        if (!rst) begin
            host_ack_q = 1'b0;
            run_req_q  = 1'b0;
            run_ack_q  = 1'b0;
            res_req_q  = 1'b0;
        end else begin
            if (prog_we) prog_mem[prog.addr] = prog.instr;
            if (host_ack && !host_ack_q && host_smem.we) begin
                smem[host_smem.addr] = host_smem.data;   // Write already done
            end
            if (run_req && !run_req_q) model_run(run_cmd.frame);
            if (res_req && !res_req_q) check_result(result);
            if (run_ack && !run_ack_q) got_status = run_status;
            host_ack_q = host_ack;
            run_req_q  = run_req;
            run_ack_q  = run_ack;
            res_req_q  = res_req;
        end
    end

    task automatic end_test(input int idx, input mix_pkg::run_status_t exp_st, input int exp_n);
        if (got_status !== exp_st) begin
            $display("[FAIL] %0t run_status got %h expected %h", $time, got_status, exp_st);
            errs++;
        end
        if (n_seen != exp_n || exp_q.size() != 0) begin
            $display("Test %0d saw %0d results but %0d were expected", idx, n_seen, exp_n);
            errs++;
        end
        if (errs == 0) begin
            $display("Test %0d passed", idx);
            pass_tests++;
        end else begin
            $display("Test %0d failed with %0d errors", idx, errs);
            fail_tests++;
        end
        errs       = 0;
        n_seen     = 0;
        got_status = 'x;
        exp_q.delete();
    endtask

    task automatic report();
        $display("Tests passed %0d, failed %0d", pass_tests, fail_tests);
    endtask

endmodule

//--- tb_mix_engine.sv
`timescale 1ns/1ps
`include "mix_defs.svh"

module tb_mix_engine;

    function automatic logic [31:0] mac_w(input logic [6:0] op, input logic [3:0] chan,
                                          input logic [4:0] ofs);
        return {op, ofs, chan, 16'h0000};   // Gain filled at run time
    endfunction

    function automatic logic [31:0] out_w(input logic [2:0] sh, input logic [3:0] slot);
        return {`MIX_OP_OUT, 14'h0, sh, slot, 4'h0};
    endfunction

    typedef struct packed {
        logic [4:0]           frame;
        logic                 noise;    // Host writes to channel 15 during the run
        mix_pkg::run_status_t status;
        logic [3:0]           n_out;
    } case_t;

    localparam int NTEST = 5;
    localparam int NSTEP = 8;
    localparam int LIMIT = 400 * NTEST * NSTEP + 1000;
    localparam logic [31:0] ILLEGAL = {7'h13, 25'h0};

    localparam logic [31:0] PROG [NTEST][NSTEP] = '{
        '{mac_w(`MIX_OP_MACZ, 3, 2), out_w(0, 5), 0, 0, 0, 0, 0, 0},
        '{mac_w(`MIX_OP_MACZ, 1, 9), mac_w(`MIX_OP_MAC, 6, 0), mac_w(`MIX_OP_MAC, 9, 30),
          mac_w(`MIX_OP_MAC, 12, 17), out_w(3, 2), 0, 0, 0},
        '{mac_w(`MIX_OP_MACZ, 2, 1), mac_w(`MIX_OP_MAC, 4, 3), out_w(0, 1),
          mac_w(`MIX_OP_MACZ, 5, 7), mac_w(`MIX_OP_MAC, 2, 1), out_w(7, 9), 0, 0},
        '{mac_w(`MIX_OP_MACZ, 0, 0), mac_w(`MIX_OP_MAC, 7, 31), out_w(1, 3),
          mac_w(`MIX_OP_MAC, 10, 5), out_w(2, 4), 0, 0, 0},
        '{mac_w(`MIX_OP_MACZ, 8, 4), out_w(0, 6), ILLEGAL, out_w(0, 7), 0, 0, 0, 0}
    };

    localparam case_t CASES [NTEST] = '{
        '{frame: 5'd0,  noise: 1'b0, status: '{error: 1'b0, halt_addr: 8'd2}, n_out: 4'd1},
        '{frame: 5'd27, noise: 1'b0, status: '{error: 1'b0, halt_addr: 8'd5}, n_out: 4'd1},
        '{frame: 5'd4,  noise: 1'b0, status: '{error: 1'b0, halt_addr: 8'd6}, n_out: 4'd2},
        '{frame: 5'd13, noise: 1'b1, status: '{error: 1'b0, halt_addr: 8'd5}, n_out: 4'd2},
        '{frame: 5'd1,  noise: 1'b0, status: '{error: 1'b1, halt_addr: 8'd2}, n_out: 4'd1}
    };

    logic                 ck, rst, prog_we, host_req, host_ack;
    logic                 run_req, run_ack, res_req, res_ack;
    mix_pkg::host_prog_t  prog;
    mix_pkg::smem_req_t   host_smem;
    mix_pkg::run_cmd_t    run_cmd;
    mix_pkg::run_status_t run_status;
    mix_pkg::mix_result_t result;
    logic [31:0]          lfsr = 32'hf86f7720;
    int                   cycles = 0;

    mix_engine_top u_mix_engine_top (.ck(ck), .rst(rst), .prog_we(prog_we), .prog(prog),
        .host_req(host_req), .host_ack(host_ack), .host_smem(host_smem), .run_req(run_req),
        .run_ack(run_ack), .run_cmd(run_cmd), .run_status(run_status), .res_req(res_req),
        .res_ack(res_ack), .result(result));

    mix_monitor u_mix_monitor (.ck(ck), .rst(rst), .prog_we(prog_we), .prog(prog),
        .host_ack(host_ack), .host_smem(host_smem), .run_req(run_req), .run_ack(run_ack),
        .run_cmd(run_cmd), .run_status(run_status), .res_req(res_req), .result(result));

    bind sample_arbiter mix_checker u_mix_checker (.ck(ck), .rst(rst), .host_req(host_req),
        .host_ack(host_ack), .seq_req(seq_req), .seq_ack(seq_ack));

    always #2 ck = ~ck;

    always @(posedge ck) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("Timeout: tests did not finish within %0d cycles", LIMIT);
            $display("TB FAILED");
            $finish;
        end
    end

    // Taps 32, 22, 2, 1, one step per bit
    function automatic logic [31:0] lfsr_take(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    task automatic host_write(input logic [8:0] addr, input logic [15:0] data);
        @(negedge ck);
        host_smem = '{we: 1'b1, addr: addr, data: data};
        host_req  = 1'b1;
        do @(negedge ck); while (!host_ack);
        host_req = 1'b0;
        do @(negedge ck); while (host_ack);
    endtask

    task automatic prog_write(input logic [7:0] addr, input mix_pkg::instr_u word);
        @(negedge ck);
        prog    = '{addr: addr, instr: word};
        prog_we = 1'b1;
        @(negedge ck);
        prog_we = 1'b0;
    endtask

    task automatic run_program(input logic [4:0] frame);
        @(negedge ck);
        run_cmd = '{frame: frame};
        run_req = 1'b1;
        do @(negedge ck); while (!run_ack);
        run_req = 1'b0;
        do @(negedge ck); while (run_ack);
    endtask

    // Result sink with a random ack delay
    initial begin
        res_ack = 1'b0;
        forever begin
            @(negedge ck);
            if (res_req && !res_ack) begin
                repeat (lfsr_take(3)) @(negedge ck);
                res_ack = 1'b1;
                do @(negedge ck); while (res_req);
                res_ack = 1'b0;
            end
        end
    end

    initial begin
        mix_pkg::instr_u ins;
        logic [4:0]      fr;
        ck        = 1'b0;
        rst       = 1'b0;
        prog_we   = 1'b0;
        prog      = '0;
        host_req  = 1'b0;
        host_smem = '0;
        run_req   = 1'b0;
        run_cmd   = '0;
        repeat (16) @(negedge ck);
        rst = 1'b1;
        for (int t = 0; t < NTEST; t++) begin
            for (int s = 0; s < NSTEP; s++) begin
                ins = PROG[t][s];
                if (ins.mac_f.op == `MIX_OP_MAC || ins.mac_f.op == `MIX_OP_MACZ) begin
                    ins.mac_f.gain = 16'(lfsr_take(16));
                    fr = CASES[t].frame + ins.mac_f.offset;
                    host_write({ins.mac_f.chan, fr}, 16'(lfsr_take(16)));
                end
                prog_write(8'(s), ins);
            end
            fork
                run_program(CASES[t].frame);
                if (CASES[t].noise) begin
                    repeat (3) begin
                        repeat (4) @(negedge ck);
                        host_write({4'hf, 5'(lfsr_take(5))}, 16'(lfsr_take(16)));
                    end
                end
            join
            u_mix_monitor.end_test(t, CASES[t].status, CASES[t].n_out);
        end
        repeat (4) @(negedge ck);
        u_mix_monitor.report();
        if (u_mix_monitor.fail_tests == 0 &&
            u_mix_engine_top.u_sample_arbiter.u_mix_checker.fail_cnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- src.f
+incdir+.
mix_pkg.sv
coef_ram.sv
sample_ram.sv
sample_arbiter.sv
mac_unit.sv
mix_sequencer.sv
mix_engine_top.sv
mix_checker.sv
mix_monitor.sv
tb_mix_engine.sv
